// File: logic/dcache_pkg.sv
package dcache_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~

  typedef logic [15:0] addr_t;  // Word address.
  typedef logic [31:0] data_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Channel payloads
  // ~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic  we;     // Store when set, load otherwise.
    addr_t addr;
    data_t wdata;
  } cpu_req_t;

  typedef struct packed {
    data_t rdata;  // Zero on a store acknowledge.
  } cpu_rsp_t;

  // Line write-back (we set) or line read.
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  typedef enum logic [2:0] {idle, compare_tag, write_back, allocate, cache_access} ctrl_state_t;

endpackage

// File: logic/dcache_tag_store.sv
module dcache_tag_store #(
  parameter int INDEX_W = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 lookup_en,
  input  dcache_pkg::addr_t    lookup_addr,
  input  logic                 tag_write,
  input  logic                 set_dirty,
  input  logic                 set_valid,
  output logic                 hit,
  output logic                 dirty,
  output logic [15-INDEX_W:0]  victim_tag
);

  localparam int TAG_W = 16 - INDEX_W;
  localparam int LINES = 1 << INDEX_W;

  typedef logic [TAG_W-1:0] tag_t;

  logic [LINES-1:0]   valid_bits;
  logic [LINES-1:0]   dirty_bits;
  tag_t               tag_mem [LINES];

  logic [INDEX_W-1:0] idx;
  tag_t               req_tag;
  logic               valid_q;
  logic               dirty_q;
  tag_t               tag_q;
  tag_t               req_tag_q;

  // The write tag is the tag field of the held request address.
  assign idx     = lookup_addr[INDEX_W-1:0];
  assign req_tag = lookup_addr[15:INDEX_W];

  // ~~~~~~~~~~~~~~~~~~~~
  // Entry update
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (tag_write) begin
      valid_bits[idx] <= set_valid;
      dirty_bits[idx] <= set_dirty;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_write) tag_mem[idx] <= req_tag;
  end

  // Lookup result is registered and compared one cycle later.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
      dirty_q <= 1'b0;
    end else if (lookup_en) begin
      valid_q <= valid_bits[idx];
      dirty_q <= dirty_bits[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_en) begin
      tag_q     <= tag_mem[idx];
      req_tag_q <= req_tag;
    end
  end

  assign hit        = valid_q && (tag_q == req_tag_q);
  assign dirty      = dirty_q;
  assign victim_tag = tag_q;

endmodule

// File: logic/dcache_data_store.sv
module dcache_data_store #(
  parameter int INDEX_W = 4
) (
  input  logic                clk,
  input  logic                rd_en,
  input  logic [INDEX_W-1:0]  index,
  input  logic                wr_en,
  input  logic                fill_sel,
  input  dcache_pkg::data_t   cpu_wdata,
  input  dcache_pkg::data_t   fill_data,
  output dcache_pkg::data_t   rd_data
);

  localparam int LINES = 1 << INDEX_W;

  dcache_pkg::data_t line_mem [LINES];
  dcache_pkg::data_t wr_data;

  // ~~~~~~~~~~~~~~~~~~~~
  // Write port
  // ~~~~~~~~~~~~~~~~~~~~

  // A fill brings the line in from memory, otherwise the word comes from a store.
  assign wr_data = fill_sel ? fill_data : cpu_wdata;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      line_mem[index] <= wr_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Read port
  // ~~~~~~~~~~~~~~~~~~~~

  // The read word is held until the next lookup.
  // A write-back relies on this to keep its payload steady.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= line_mem[index];
    end
  end

endmodule

// File: logic/dcache_ctrl.sv
module dcache_ctrl #(
  parameter int INDEX_W = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  // CPU side.
  input  logic                  cpu_req_valid,
  input  dcache_pkg::cpu_req_t  cpu_req,
  output logic                  cpu_req_ready,
  output logic                  cpu_rsp_valid,
  output dcache_pkg::cpu_rsp_t  cpu_rsp,
  // Memory side.
  output logic                  mem_req_valid,
  output dcache_pkg::mem_req_t  mem_req,
  input  logic                  mem_req_ready,
  input  logic                  mem_rsp_valid,
  input  dcache_pkg::data_t     mem_rsp_data,
  // Tag store.
  output logic                  lookup_en,
  output dcache_pkg::addr_t     lookup_addr,
  output logic                  tag_write,
  output logic                  set_dirty,
  output logic                  set_valid,
  input  logic                  hit,
  input  logic                  dirty,
  input  logic [15-INDEX_W:0]   victim_tag,
  // Data store.
  output logic                  rd_en,
  output logic [INDEX_W-1:0]    index,
  output logic                  wr_en,
  output logic                  fill_sel,
  output dcache_pkg::data_t     cpu_wdata,
  input  dcache_pkg::data_t     rd_data
);

  dcache_pkg::ctrl_state_t state_q, state_d;
  dcache_pkg::cpu_req_t    req_q;
  dcache_pkg::data_t       fill_q;
  logic                    read_sent_q;
  logic                    accept;
  logic                    fill_done;

  assign cpu_req_ready = (state_q == dcache_pkg::idle);
  assign accept        = cpu_req_valid && cpu_req_ready;
  assign fill_done     = (state_q == dcache_pkg::allocate) && read_sent_q && mem_rsp_valid;

  // Both stores look up at the transfer edge, later cycles use the held address.
  assign lookup_en   = accept;
  assign rd_en       = accept;
  assign lookup_addr = cpu_req_ready ? cpu_req.addr : req_q.addr;
  assign index       = lookup_addr[INDEX_W-1:0];
  assign cpu_wdata   = req_q.wdata;

  // ~~~~~~~~~~~~~~~~~~~~
  // Registers
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q     <= dcache_pkg::idle;
      read_sent_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (fill_done)
        read_sent_q <= 1'b0;
      else if (state_q == dcache_pkg::allocate && mem_req_valid && mem_req_ready)
        read_sent_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) req_q <= cpu_req;
    if (fill_done) fill_q <= mem_rsp_data;  // Load data for cache_access.
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Next state and outputs
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_d       = state_q;
    tag_write     = 1'b0;
    set_dirty     = 1'b0;
    set_valid     = 1'b0;
    wr_en         = 1'b0;
    fill_sel      = 1'b0;
    cpu_rsp_valid = 1'b0;
    cpu_rsp       = '0;
    mem_req_valid = 1'b0;
    mem_req       = '0;
    case (state_q)
      dcache_pkg::idle: begin
        if (accept) state_d = dcache_pkg::compare_tag;
      end
      dcache_pkg::compare_tag: begin
        if (hit) begin
          cpu_rsp_valid = 1'b1;
          if (req_q.we) begin
            wr_en     = 1'b1;
            tag_write = 1'b1;
            set_valid = 1'b1;
            set_dirty = 1'b1;
          end else begin
            cpu_rsp.rdata = rd_data;
          end
          state_d = dcache_pkg::idle;
        end else if (dirty) begin
          state_d = dcache_pkg::write_back;
        end else begin
          state_d = dcache_pkg::allocate;
        end
      end
      dcache_pkg::write_back: begin
        // Victim address and word stay put while we wait for ready.
        mem_req_valid = 1'b1;
        mem_req.we    = 1'b1;
        mem_req.addr  = {victim_tag, req_q.addr[INDEX_W-1:0]};
        mem_req.wdata = rd_data;
        if (mem_req_ready) state_d = dcache_pkg::allocate;
      end
      dcache_pkg::allocate: begin
        mem_req_valid = !read_sent_q;
        mem_req.addr  = req_q.addr;
        if (fill_done) begin
          wr_en     = 1'b1;
          fill_sel  = 1'b1;
          tag_write = 1'b1;
          set_valid = 1'b1;  // Clean after a fill.
          state_d   = dcache_pkg::cache_access;
        end
      end
      dcache_pkg::cache_access: begin
        cpu_rsp_valid = 1'b1;
        if (req_q.we) begin
          wr_en     = 1'b1;
          tag_write = 1'b1;
          set_valid = 1'b1;
          set_dirty = 1'b1;
        end else begin
          cpu_rsp.rdata = fill_q;
        end
        state_d = dcache_pkg::idle;
      end
      default: state_d = dcache_pkg::idle;
    endcase
  end

endmodule

// File: logic/dcache_top.sv
module dcache_top #(
  parameter int INDEX_W = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cpu_req_valid,
  input  dcache_pkg::cpu_req_t  cpu_req,
  output logic                  cpu_req_ready,
  output logic                  cpu_rsp_valid,
  output dcache_pkg::cpu_rsp_t  cpu_rsp,
  output logic                  mem_req_valid,
  output dcache_pkg::mem_req_t  mem_req,
  input  logic                  mem_req_ready,
  input  logic                  mem_rsp_valid,
  input  dcache_pkg::data_t     mem_rsp_data
);

  localparam int TAG_W = 16 - INDEX_W;

  // Tag store wires.
  logic               lookup_en;
  dcache_pkg::addr_t  lookup_addr;
  logic               tag_write;
  logic               set_dirty;
  logic               set_valid;
  logic               hit;
  logic               dirty;
  logic [TAG_W-1:0]   victim_tag;

  // Data store wires.
  logic               rd_en;
  logic [INDEX_W-1:0] index;
  logic               wr_en;
  logic               fill_sel;
  dcache_pkg::data_t  cpu_wdata;
  dcache_pkg::data_t  rd_data;

  dcache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (.*);

  dcache_tag_store #(.INDEX_W(INDEX_W)) u_tag_store (
    .clk, .rst, .lookup_en, .lookup_addr, .tag_write, .set_dirty, .set_valid,
    .hit, .dirty, .victim_tag
  );

  dcache_data_store #(.INDEX_W(INDEX_W)) u_data_store (
    .clk, .rd_en, .index, .wr_en, .fill_sel, .cpu_wdata,
    .fill_data (mem_rsp_data),  // Fill words go straight into the array.
    .rd_data
  );

endmodule

// File: test/dcache_chk.sv
module dcache_chk (
  input logic                 clk,
  input logic                 rst,
  input logic                 cpu_req_valid,
  input logic                 cpu_req_ready,
  input logic                 cpu_rsp_valid,
  input logic                 mem_req_valid,
  input dcache_pkg::mem_req_t mem_req,
  input logic                 mem_req_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  int   fail_count = 0;
  logic busy;  // A transfer is still waiting for its response.

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (cpu_req_valid && cpu_req_ready) begin
      busy <= 1'b1;
    end else if (cpu_rsp_valid) begin
      busy <= 1'b0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Memory channel
  // ~~~~~~~~~~~~~~~~~~~~

  mem_req_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else begin
      fail_count++;
      $error("memory request dropped or changed before it was accepted");
    end

  // ~~~~~~~~~~~~~~~~~~~~
  // CPU channel
  // ~~~~~~~~~~~~~~~~~~~~

  ready_low_while_busy: assert property (@(posedge clk) disable iff (rst)
    busy |-> !cpu_req_ready)
    else begin
      fail_count++;
      $error("cpu_req_ready rose before the response of the held request");
    end

  rsp_needs_request: assert property (@(posedge clk) disable iff (rst)
    cpu_rsp_valid |-> busy)
    else begin
      fail_count++;
      $error("response pulse without an outstanding transfer");
    end

  no_transfer_while_busy: assert property (@(posedge clk) disable iff (rst)
    (cpu_req_valid && cpu_req_ready) |-> !busy)
    else begin
      fail_count++;
      $error("new transfer before the previous one was answered");
    end

endmodule

bind dcache_top dcache_chk u_chk (.*);

// File: test/dcache_tb.sv
module dcache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CYCLES = 4000;  // About 300 requests at up to ten cycles, with margin.
  localparam int RAND_OPS   = 300;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 cpu_req_valid;
  dcache_pkg::cpu_req_t cpu_req;
  logic                 cpu_req_ready;
  logic                 cpu_rsp_valid;
  dcache_pkg::cpu_rsp_t cpu_rsp;
  logic                 mem_req_valid;
  dcache_pkg::mem_req_t mem_req;
  logic                 mem_req_ready;
  logic                 mem_rsp_valid;
  dcache_pkg::data_t    mem_rsp_data;

  dcache_pkg::data_t mem_model [65536];
  dcache_pkg::data_t shadow [65536];   // Expected contents as the CPU sees them.
  dcache_pkg::data_t exp_q [$];
  integer            seed = 32'hd2bc_65ad;
  int                errors = 0;
  int                checks = 0;
  int                cycles = 0;
  int                accept_cycle = 0;
  int                latency = 0;
  int                rd_count = 0;
  int                wr_count = 0;
  int                rsp_wait = 0;
  logic              next_ready;
  dcache_pkg::data_t rd_word;
  dcache_pkg::addr_t last_rd_addr;
  dcache_pkg::addr_t last_wr_addr;
  dcache_pkg::data_t last_wr_data;

  dcache_top #(.INDEX_W(4)) DUT (.*);

  always #4 clk = ~clk;

  function automatic dcache_pkg::data_t init_word(input dcache_pkg::addr_t a);
    return {a, ~a} ^ 32'h9e37_79b9;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic clear_counts();
    rd_count = 0;
    wr_count = 0;
  endtask

  // Keeps valid high up to the response pulse, so an early second transfer would show.
  task automatic issue_request(input logic we, input dcache_pkg::addr_t addr,
                               input dcache_pkg::data_t wdata);
    cpu_req_valid = 1'b1;
    cpu_req.we    = we;
    cpu_req.addr  = addr;
    cpu_req.wdata = wdata;
    do @(posedge clk); while (!cpu_req_ready);
    do @(posedge clk); while (!cpu_rsp_valid);
    #1 cpu_req_valid = 1'b0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Memory model
  // ~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    if (mem_req_valid && mem_req_ready) begin
      if (mem_req.we) begin
        mem_model[mem_req.addr] = mem_req.wdata;
        last_wr_addr = mem_req.addr;
        last_wr_data = mem_req.wdata;
        wr_count++;
      end else begin
        rd_word      = mem_model[mem_req.addr];
        last_rd_addr = mem_req.addr;
        rd_count++;
        rsp_wait = 1 + ($unsigned($random(seed)) % 3);  // Fill arrives 1 to 3 cycles later.
      end
    end else if (rsp_wait > 0) begin
      rsp_wait--;
    end
    next_ready = ($random(seed) & 3) != 0;
    #1;
    mem_req_ready = next_ready;
    mem_rsp_valid = (rsp_wait == 1);
    mem_rsp_data  = (rsp_wait == 1) ? rd_word : '0;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Response monitor
  // ~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    cycles++;
    if (!rst && cpu_req_valid && cpu_req_ready) begin
      accept_cycle = cycles;
      if (cpu_req.we) begin
        shadow[cpu_req.addr] = cpu_req.wdata;
        exp_q.push_back('0);  // Stores are acknowledged with zero.
      end else begin
        exp_q.push_back(shadow[cpu_req.addr]);
      end
    end
    if (!rst && cpu_rsp_valid) begin
      latency = cycles - accept_cycle;
      checks++;
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("response pulse arrived with no request waiting for it");
      end
      if (exp_q.size() > 0) compare_value("cpu_rsp.rdata", cpu_rsp.rdata, exp_q.pop_front());
    end
  end

  initial begin
    wait (cycles >= MAX_CYCLES);
    $display("timeout: run stopped after %0d cycles, checks %0d, errors %0d",
             cycles, checks, errors);
    $display("TEST FAILED");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~

  initial begin
    logic [31:0] r;
    int          total;
    rst           = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req       = '0;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_data  = '0;
    for (int i = 0; i < 65536; i++) begin
      mem_model[i] = init_word(i);
      shadow[i]    = init_word(i);
    end
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;

    compare_value("cpu_req_ready", cpu_req_ready, 1);
    compare_value("cpu_rsp_valid", cpu_rsp_valid, 0);
    compare_value("mem_req_valid", mem_req_valid, 0);
    clear_counts();
    issue_request(1'b0, 16'h0123, '0);  // Cold miss.
    compare_value("mem read count", rd_count, 1);
    compare_value("mem read addr", last_rd_addr, 16'h0123);
    compare_value("mem write count", wr_count, 0);

    clear_counts();
    issue_request(1'b0, 16'h0123, '0);
    compare_value("hit latency", latency, 1);
    compare_value("mem request count", rd_count + wr_count, 0);

    clear_counts();
    issue_request(1'b1, 16'h0123, 32'hcafe_f00d);
    compare_value("store hit latency", latency, 1);
    issue_request(1'b0, 16'h0123, '0);
    compare_value("mem request count", rd_count + wr_count, 0);

    // Same index, other tag, so the dirty line goes back first.
    clear_counts();
    issue_request(1'b0, 16'h0453, '0);
    compare_value("mem write count", wr_count, 1);
    compare_value("mem write addr", last_wr_addr, 16'h0123);
    compare_value("mem write data", last_wr_data, 32'hcafe_f00d);
    compare_value("mem read count", rd_count, 1);
    compare_value("mem read addr", last_rd_addr, 16'h0453);
    issue_request(1'b0, 16'h0123, '0);

    repeat (RAND_OPS) begin
      r = $random(seed);
      issue_request(r[8], 16'h2000 | {11'h0, r[4:0]}, $random(seed));
    end

    repeat (2) @(posedge clk);
    total = errors + DUT.u_chk.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, DUT.u_chk.fail_count);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: dcache.f
logic/dcache_pkg.sv
logic/dcache_tag_store.sv
logic/dcache_data_store.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
test/dcache_chk.sv
test/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - logic/dcache_pkg.sv
      - logic/dcache_tag_store.sv
      - logic/dcache_data_store.sv
      - logic/dcache_ctrl.sv
      - logic/dcache_top.sv
  - target: test
    files:
      - test/dcache_chk.sv
      - test/dcache_tb.sv
